/* fetch_params.svh */
//**********************************************************************
// Fetch front end parameters: widths, predictor and store sizing,
// reset address and instruction store fault window
//**********************************************************************
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// PC and address widths
`define FETCH_XLEN          64
`define FETCH_VADDR_BITS    39
`define FETCH_REQ_ADDR_BITS 40

// Branch predictor table entries
`define FETCH_BP_ENTRIES    16

// Instruction store depth and content pattern
`define FETCH_MEM_WORDS     256
`define FETCH_MEM_PATTERN   32'h1300_0013

// Page fault window, base inclusive and limit exclusive
`define FETCH_PF_BASE       40'h0000_2000
`define FETCH_PF_LIMIT      40'h0000_3000

// Address the PC takes during reset
`define FETCH_RESET_ADDR    40'h0000_0100

`endif

/* fetch_pkg.sv */
//**********************************************************************
// Fetch package: address types, select and cause encodings, and the
// structs passed between the fetch stage, predictor and store
//**********************************************************************
`include "fetch_params.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0]          addr_pc_t;
    typedef logic [`FETCH_REQ_ADDR_BITS-1:0] addr_t;
    typedef logic [31:0]                     inst_t;

    // Next PC source chosen by the control unit
    typedef enum logic [1:0] {
        KEEP_PC,
        BP_OR_PC_4,
        JUMP,
        DEBUG
    } next_pc_sel_t;

    // RISC-V mcause encodings for fetch exceptions
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        INSTR_PAGE_FAULT      = 4'd12
    } xcpt_cause_t;

    typedef enum logic {
        PRED_NOT_TAKEN,
        PRED_TAKEN
    } pred_decision_t;

    typedef struct packed {
        next_pc_sel_t next_pc;
    } cu_if_t;

    // Fetch request towards the instruction store
    typedef struct packed {
        logic  valid;
        addr_t vaddr;
        logic  invalidate_icache;
        logic  invalidate_buffer;
    } req_fetch_mem_t;

    typedef struct packed {
        logic  valid;
        inst_t data;
        logic  instr_page_fault;
    } resp_mem_fetch_t;

    // Resolved branch coming back from execute
    typedef struct packed {
        logic     is_branch;
        logic     taken;
        addr_pc_t pc_execution;
        addr_pc_t branch_addr_result;
    } exe_bpred_update_t;

    typedef struct packed {
        logic           is_branch;
        pred_decision_t decision;
        addr_pc_t       pred_addr;
    } bpred_t;

    typedef struct packed {
        logic        valid;
        xcpt_cause_t cause;
        addr_pc_t    origin;
    } xcpt_t;

    // One packet per cycle to decode
    typedef struct packed {
        logic     valid;
        addr_pc_t pc_inst;
        inst_t    inst;
        xcpt_t    ex;
        bpred_t   bpred;
    } fetch_pkt_t;

endpackage

/* branch_predictor.sv */
//**********************************************************************
// Branch predictor with 2-bit counters and a tagged target buffer
//**********************************************************************
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predictor (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  fetch_pkg::addr_pc_t           pc_fetch_i,
    input  fetch_pkg::exe_bpred_update_t  update_i,
    output logic                          is_branch_o,
    output logic                          taken_o,
    output fetch_pkg::addr_pc_t           pred_addr_o
);
    import fetch_pkg::*;

    localparam int IDX_BITS = $clog2(`FETCH_BP_ENTRIES);
    localparam int TAG_LSB  = IDX_BITS + 2;
    localparam int TAG_BITS = `FETCH_XLEN - TAG_LSB;

    logic [1:0]          counters [`FETCH_BP_ENTRIES];
    logic                valids   [`FETCH_BP_ENTRIES];
    logic [TAG_BITS-1:0] tags     [`FETCH_BP_ENTRIES];
    addr_pc_t            targets  [`FETCH_BP_ENTRIES];

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] upd_idx;
    logic [TAG_BITS-1:0] rd_tag;

    // Word aligned index, upper bits form the tag
    assign rd_idx  = pc_fetch_i[TAG_LSB-1:2];
    assign rd_tag  = pc_fetch_i[`FETCH_XLEN-1:TAG_LSB];
    assign upd_idx = update_i.pc_execution[TAG_LSB-1:2];

    assign is_branch_o = valids[rd_idx] && (tags[rd_idx] == rd_tag);
    assign taken_o     = counters[rd_idx][1];
    assign pred_addr_o = targets[rd_idx];

    // Counters and valid bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `FETCH_BP_ENTRIES; i++) begin
                counters[i] <= 2'b01;
                valids[i]   <= 1'b0;
            end
        end else if (update_i.is_branch) begin
            valids[upd_idx] <= 1'b1;
            if (update_i.taken) begin
                if (counters[upd_idx] != 2'b11) begin
                    counters[upd_idx] <= counters[upd_idx] + 2'b01;
                end
            end else if (counters[upd_idx] != 2'b00) begin
                counters[upd_idx] <= counters[upd_idx] - 2'b01;
            end
        end
    end

    // Tag and target payload
    always_ff @(posedge clk_i) begin
        if (update_i.is_branch) begin
            tags[upd_idx]    <= update_i.pc_execution[`FETCH_XLEN-1:TAG_LSB];
            targets[upd_idx] <= update_i.branch_addr_result;
        end
    end

    // Trained counter stays known and saturates instead of wrapping
    a_counter_range: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        update_i.is_branch |=> !$isunknown(counters[$past(upd_idx)])
                               && !(($past(counters[upd_idx]) == 2'b11)
                                    && (counters[$past(upd_idx)] == 2'b00))
                               && !(($past(counters[upd_idx]) == 2'b00)
                                    && (counters[$past(upd_idx)] == 2'b11))
    );

endmodule

/* fetch_stage.sv */
//**********************************************************************
// Fetch stage: PC register and next PC selection, exception checks,
// instruction request and fetch packet assembly
//**********************************************************************
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_stage (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fetch_pkg::addr_t            reset_addr_i,
    input  logic                        stall_i,
    input  logic                        stall_debug_i,
    input  fetch_pkg::cu_if_t           cu_if_i,
    input  logic                        invalidate_icache_i,
    input  logic                        invalidate_buffer_i,
    input  logic                        retry_fetch_i,
    input  fetch_pkg::addr_pc_t         pc_jump_i,
    input  fetch_pkg::resp_mem_fetch_t  resp_mem_i,
    input  logic                        bp_is_branch_i,
    input  logic                        bp_taken_i,
    input  fetch_pkg::addr_pc_t         bp_addr_i,
    output fetch_pkg::req_fetch_mem_t   req_mem_o,
    output fetch_pkg::addr_pc_t         pc_o,
    output fetch_pkg::fetch_pkt_t       fetch_o
);
    import fetch_pkg::*;

    localparam int PAD_BITS = `FETCH_XLEN - `FETCH_REQ_ADDR_BITS;
    localparam int SIGN_BIT = `FETCH_VADDR_BITS - 1;

    addr_pc_t pc_q;
    addr_pc_t next_pc;
    logic     bp_hit_taken;
    logic     misaligned;
    logic     non_canonical;
    logic     page_fault;
    xcpt_t    xcpt;

    assign bp_hit_taken = bp_is_branch_i && bp_taken_i;

    always_comb begin
        unique case (cu_if_i.next_pc)
            KEEP_PC:    next_pc = pc_q;
            BP_OR_PC_4: next_pc = bp_hit_taken ? bp_addr_i : pc_q + addr_pc_t'(4);
            JUMP,
            DEBUG:      next_pc = pc_jump_i;
            default:    next_pc = pc_q + addr_pc_t'(4);
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= {{PAD_BITS{1'b0}}, reset_addr_i};
        end else begin
            pc_q <= next_pc;
        end
    end

    // Upper bits must all copy bit 38 of the virtual address
    assign misaligned    = |pc_q[1:0];
    assign non_canonical = pc_q[SIGN_BIT] ? !(&pc_q[`FETCH_XLEN-1:SIGN_BIT+1])
                                          : |pc_q[`FETCH_XLEN-1:SIGN_BIT+1];
    assign page_fault    = resp_mem_i.valid && resp_mem_i.instr_page_fault;

    // Misaligned wins, then access fault, then page fault
    always_comb begin
        xcpt.origin = pc_q;
        xcpt.valid  = misaligned || non_canonical || page_fault;
        if (misaligned) begin
            xcpt.cause = INSTR_ADDR_MISALIGNED;
        end else if (non_canonical) begin
            xcpt.cause = INSTR_ACCESS_FAULT;
        end else if (page_fault) begin
            xcpt.cause = INSTR_PAGE_FAULT;
        end else begin
            xcpt.cause = INSTR_ADDR_MISALIGNED;
        end
    end

    // No request for a misaligned PC or while debug holds the core
    assign req_mem_o.valid             = !misaligned && !stall_debug_i;
    assign req_mem_o.vaddr             = pc_q[`FETCH_REQ_ADDR_BITS-1:0];
    assign req_mem_o.invalidate_icache = invalidate_icache_i;
    assign req_mem_o.invalidate_buffer = invalidate_buffer_i | retry_fetch_i;

    assign pc_o = pc_q;

    always_comb begin
        fetch_o.valid           = !stall_i && !stall_debug_i
                                  && (resp_mem_i.valid || xcpt.valid);
        fetch_o.pc_inst         = pc_q;
        fetch_o.inst            = resp_mem_i.data;
        fetch_o.ex              = xcpt;
        fetch_o.bpred.is_branch = bp_is_branch_i;
        fetch_o.bpred.decision  = bp_hit_taken ? PRED_TAKEN : PRED_NOT_TAKEN;
        fetch_o.bpred.pred_addr = bp_addr_i;
    end

    a_cu_known: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(cu_if_i)
    );

    // A misaligned PC never reaches the store, so nothing comes back
    a_misaligned_no_req: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        misaligned |-> !resp_mem_i.valid
    );

endmodule

/* instr_store.sv */
//**********************************************************************
// Single-cycle instruction store with patterned contents, a page
// fault window and a blank response after invalidation
//**********************************************************************
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_store (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    input  fetch_pkg::req_fetch_mem_t   req_i,
    output fetch_pkg::resp_mem_fetch_t  resp_o
);
    import fetch_pkg::*;

    localparam int IDX_BITS = $clog2(`FETCH_MEM_WORDS);

    inst_t               rom [`FETCH_MEM_WORDS];
    logic [IDX_BITS-1:0] word_idx;
    logic                inval_q;
    logic                in_pf_window;

    // Word i holds i XOR the pattern
    for (genvar i = 0; i < `FETCH_MEM_WORDS; i++) begin : g_rom
        assign rom[i] = `FETCH_MEM_PATTERN ^ 32'(i);
    end

    assign word_idx = req_i.vaddr[IDX_BITS+1:2];

    // Remember an invalidate for exactly one cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            inval_q <= 1'b0;
        end else begin
            inval_q <= req_i.invalidate_icache | req_i.invalidate_buffer;
        end
    end

    assign in_pf_window = (req_i.vaddr >= `FETCH_PF_BASE)
                          && (req_i.vaddr < `FETCH_PF_LIMIT);

    assign resp_o.valid            = req_i.valid && !inval_q;
    assign resp_o.data             = rom[word_idx];
    assign resp_o.instr_page_fault = req_i.valid && !inval_q && in_pf_window;

endmodule

/* fetch_top.sv */
//**********************************************************************
// Fetch front end top: fetch stage, branch predictor, instruction store
//**********************************************************************
`timescale 1ns/1ps

module fetch_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  fetch_pkg::addr_t              reset_addr_i,
    input  logic                          stall_i,
    input  logic                          stall_debug_i,
    input  fetch_pkg::cu_if_t             cu_if_i,
    input  logic                          invalidate_icache_i,
    input  logic                          invalidate_buffer_i,
    input  logic                          retry_fetch_i,
    input  fetch_pkg::addr_pc_t           pc_jump_i,
    input  fetch_pkg::exe_bpred_update_t  exe_bpred_i,
    output fetch_pkg::fetch_pkt_t         fetch_o
);
    import fetch_pkg::*;

    req_fetch_mem_t  req_mem;
    resp_mem_fetch_t resp_mem;
    addr_pc_t        pc;
    logic            bp_is_branch;
    logic            bp_taken;
    addr_pc_t        bp_addr;

    fetch_stage u_fetch_stage (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .stall_i             (stall_i),
        .stall_debug_i       (stall_debug_i),
        .cu_if_i             (cu_if_i),
        .invalidate_icache_i (invalidate_icache_i),
        .invalidate_buffer_i (invalidate_buffer_i),
        .retry_fetch_i       (retry_fetch_i),
        .pc_jump_i           (pc_jump_i),
        .resp_mem_i          (resp_mem),
        .bp_is_branch_i      (bp_is_branch),
        .bp_taken_i          (bp_taken),
        .bp_addr_i           (bp_addr),
        .req_mem_o           (req_mem),
        .pc_o                (pc),
        .fetch_o             (fetch_o)
    );

    branch_predictor u_branch_predictor (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pc_fetch_i  (pc),
        .update_i    (exe_bpred_i),
        .is_branch_o (bp_is_branch),
        .taken_o     (bp_taken),
        .pred_addr_o (bp_addr)
    );

    instr_store u_instr_store (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (req_mem),
        .resp_o (resp_mem)
    );

endmodule

/* fetch_checker.sv */
//**********************************************************************
// Fetch packet checker: compares the DUT fetch packet with the
// expected row and reports one line per row
//**********************************************************************
`timescale 1ns/1ps

module fetch_checker (
    input  logic                   clk_i,
    input  logic                   check_en_i,
    input  int                     row_i,
    input  fetch_pkg::fetch_pkt_t  exp_i,
    input  fetch_pkg::fetch_pkt_t  fetch_i,
    output int                     pass_cnt_o,
    output int                     fail_cnt_o
);
    import fetch_pkg::*;

    int pass_cnt = 0;
    int fail_cnt = 0;
    int row_errs;

    assign pass_cnt_o = pass_cnt;
    assign fail_cnt_o = fail_cnt;

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error row %0d: %s is %h, expected %h", row_i, name, got, exp);
            row_errs++;
        end
    endtask

    // Sample in the low phase, once the row inputs have settled
    always @(negedge clk_i) begin
        #1;
        if (check_en_i) begin
            row_errs = 0;
            compare_field("fetch_o.valid", 64'(fetch_i.valid), 64'(exp_i.valid));
            compare_field("fetch_o.pc_inst", fetch_i.pc_inst, exp_i.pc_inst);
            // Instruction only matters for a clean fetch
            if (exp_i.valid && !exp_i.ex.valid) begin
                compare_field("fetch_o.inst", 64'(fetch_i.inst), 64'(exp_i.inst));
            end
            compare_field("fetch_o.ex.valid", 64'(fetch_i.ex.valid), 64'(exp_i.ex.valid));
            if (exp_i.ex.valid) begin
                compare_field("fetch_o.ex.cause", 64'(fetch_i.ex.cause), 64'(exp_i.ex.cause));
                compare_field("fetch_o.ex.origin", fetch_i.ex.origin, exp_i.ex.origin);
            end
            compare_field("fetch_o.bpred.is_branch", 64'(fetch_i.bpred.is_branch),
                          64'(exp_i.bpred.is_branch));
            compare_field("fetch_o.bpred.decision", 64'(fetch_i.bpred.decision),
                          64'(exp_i.bpred.decision));
            if (exp_i.bpred.is_branch) begin
                compare_field("fetch_o.bpred.pred_addr", fetch_i.bpred.pred_addr,
                              exp_i.bpred.pred_addr);
            end
            if (row_errs == 0) begin
                pass_cnt++;
                $display("Row %0d at pc %h: ok", row_i, exp_i.pc_inst);
            end else begin
                fail_cnt++;
                $display("Row %0d at pc %h: %0d mismatches", row_i, exp_i.pc_inst, row_errs);
            end
        end
    end

endmodule

/* tb_fetch.sv */
//**********************************************************************
// Fetch front end testbench: a stimulus table with expected fetch
// packets, applied one row per cycle on falling clock edges
//**********************************************************************
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch;
    import fetch_pkg::*;

    // Row control bits: stall, stall_debug, invalidate_icache,
    // invalidate_buffer, retry_fetch
    localparam logic [4:0]        NONE      = 5'b00000;
    localparam logic [4:0]        STALL     = 5'b10000;
    localparam logic [4:0]        STALL_DBG = 5'b01000;
    localparam logic [4:0]        INV_IC    = 5'b00100;
    localparam logic [4:0]        INV_BUF   = 5'b00010;
    localparam logic [4:0]        RETRY     = 5'b00001;
    localparam int                DONE_WAIT = 20;
    localparam addr_pc_t          BR_PC     = 64'h480;
    localparam addr_pc_t          BR_TGT    = 64'h300;
    localparam exe_bpred_update_t NO_UPD    = '0;

    typedef struct packed {
        next_pc_sel_t      sel;
        addr_pc_t          jump;
        logic              stall;
        logic              stall_dbg;
        logic              inv_icache;
        logic              inv_buffer;
        logic              retry;
        exe_bpred_update_t upd;
        fetch_pkt_t        exp;
    } row_t;

    logic              clk_i;
    logic              rstn_i;
    addr_t             reset_addr_i;
    logic              stall_i;
    logic              stall_debug_i;
    cu_if_t            cu_if_i;
    logic              invalidate_icache_i;
    logic              invalidate_buffer_i;
    logic              retry_fetch_i;
    addr_pc_t          pc_jump_i;
    exe_bpred_update_t exe_bpred_i;
    fetch_pkt_t        fetch_o;

    row_t        rows [$];
    addr_pc_t    model_pc;
    logic        model_inval;
    integer      seed;
    logic [31:0] rnd;
    addr_pc_t    tgt;
    logic        check_en;
    int          row_idx;
    fetch_pkt_t  exp_pkt;
    int          pass_cnt;
    int          fail_cnt;
    int          waited;

    fetch_top uut (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .reset_addr_i        (reset_addr_i),
        .stall_i             (stall_i),
        .stall_debug_i       (stall_debug_i),
        .cu_if_i             (cu_if_i),
        .invalidate_icache_i (invalidate_icache_i),
        .invalidate_buffer_i (invalidate_buffer_i),
        .retry_fetch_i       (retry_fetch_i),
        .pc_jump_i           (pc_jump_i),
        .exe_bpred_i         (exe_bpred_i),
        .fetch_o             (fetch_o)
    );

    fetch_checker u_checker (
        .clk_i      (clk_i),
        .check_en_i (check_en),
        .row_i      (row_idx),
        .exp_i      (exp_pkt),
        .fetch_i    (fetch_o),
        .pass_cnt_o (pass_cnt),
        .fail_cnt_o (fail_cnt)
    );

    always #2 clk_i = ~clk_i;

    function automatic exe_bpred_update_t bp_update(input logic taken, input addr_pc_t pc,
                                                    input addr_pc_t target);
        exe_bpred_update_t u;
        u.is_branch          = 1'b1;
        u.taken              = taken;
        u.pc_execution       = pc;
        u.branch_addr_result = target;
        return u;
    endfunction

    // Expected packet from the fetch rules, then step the PC model
    // pred is {is_branch, taken} as the predictor should report it
    task automatic add_row(input next_pc_sel_t sel, input addr_pc_t jump, input logic [4:0] ctl,
                           input exe_bpred_update_t upd, input logic [1:0] pred,
                           input addr_pc_t pred_addr);
        row_t r;
        logic misal;
        logic noncanon;
        logic resp_ok;
        logic pf;
        r.sel = sel;
        r.jump = jump;
        {r.stall, r.stall_dbg, r.inv_icache, r.inv_buffer, r.retry} = ctl;
        r.upd = upd;
        misal = model_pc[1:0] != 2'b00;
        noncanon = (model_pc[63:38] != '0) && (model_pc[63:38] != '1);
        resp_ok = !misal && !r.stall_dbg && !model_inval;
        pf = resp_ok && (model_pc[39:0] >= `FETCH_PF_BASE) && (model_pc[39:0] < `FETCH_PF_LIMIT);
        r.exp.pc_inst = model_pc;
        r.exp.inst = `FETCH_MEM_PATTERN ^ {24'h0, model_pc[9:2]};
        r.exp.ex.valid = misal || noncanon || pf;
        r.exp.ex.cause = misal ? INSTR_ADDR_MISALIGNED
                       : (noncanon ? INSTR_ACCESS_FAULT : INSTR_PAGE_FAULT);
        r.exp.ex.origin = model_pc;
        r.exp.valid = !r.stall && !r.stall_dbg && (resp_ok || r.exp.ex.valid);
        r.exp.bpred.is_branch = pred[1];
        r.exp.bpred.decision = (pred == 2'b11) ? PRED_TAKEN : PRED_NOT_TAKEN;
        r.exp.bpred.pred_addr = pred_addr;
        rows.push_back(r);
        if (sel == BP_OR_PC_4) begin
            model_pc = (pred == 2'b11) ? pred_addr : model_pc + 64'd4;
        end else if (sel != KEEP_PC) begin
            model_pc = jump;
        end
        model_inval = r.inv_icache || r.inv_buffer || r.retry;
    endtask

    task automatic apply_row(input row_t r);
        cu_if_i.next_pc     = r.sel;
        pc_jump_i           = r.jump;
        stall_i             = r.stall;
        stall_debug_i       = r.stall_dbg;
        invalidate_icache_i = r.inv_icache;
        invalidate_buffer_i = r.inv_buffer;
        retry_fetch_i       = r.retry;
        exe_bpred_i         = r.upd;
    endtask

    initial begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        reset_addr_i = `FETCH_RESET_ADDR;
        check_en     = 1'b0;
        row_idx      = 0;
        exp_pkt      = '0;
        apply_row('0);
        seed         = 32'h602f_08b5;
        model_pc     = {24'h0, `FETCH_RESET_ADDR};
        model_inval  = 1'b0;

        // Sequential fetch from the reset address
        for (int i = 0; i < 6; i++) begin
            add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        end
        add_row(KEEP_PC, '0, STALL, NO_UPD, 2'b00, '0);
        add_row(KEEP_PC, '0, NONE, NO_UPD, 2'b00, '0);
        add_row(KEEP_PC, '0, STALL_DBG, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        // Random word targets inside the store, jump and debug alternating
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            tgt = {54'h0, rnd[9:2], 2'b00};
            add_row((i % 2 == 0) ? JUMP : DEBUG, tgt, NONE, NO_UPD, 2'b00, '0);
        end
        add_row(JUMP, 64'h102, NONE, NO_UPD, 2'b00, '0);
        // Misaligned beats non-canonical
        add_row(JUMP, 64'h0000_0080_0000_0102, NONE, NO_UPD, 2'b00, '0);
        add_row(JUMP, 64'h0000_0080_0000_0100, NONE, NO_UPD, 2'b00, '0);
        add_row(JUMP, 64'hffff_ffc0_0000_0200, NONE, NO_UPD, 2'b00, '0);
        add_row(JUMP, 64'h2010, NONE, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        add_row(JUMP, 64'h200, NONE, NO_UPD, 2'b00, '0);
        // Each strobe blanks exactly the following fetch
        add_row(BP_OR_PC_4, '0, INV_IC, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, RETRY, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, INV_BUF, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);
        // Train taken, follow the prediction, then train down to the floor and past it
        add_row(JUMP, BR_PC, NONE, bp_update(1'b1, BR_PC, BR_TGT), 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b11, BR_TGT);
        add_row(BP_OR_PC_4, '0, NONE, bp_update(1'b0, BR_PC, BR_TGT), 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, bp_update(1'b0, BR_PC, BR_TGT), 2'b00, '0);
        add_row(JUMP, BR_PC, NONE, bp_update(1'b0, BR_PC, BR_TGT), 2'b00, '0);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b10, BR_TGT);
        add_row(BP_OR_PC_4, '0, NONE, NO_UPD, 2'b00, '0);

        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        foreach (rows[i]) begin
            @(negedge clk_i);
            apply_row(rows[i]);
            row_idx  = i;
            exp_pkt  = rows[i].exp;
            check_en = 1'b1;
        end
        @(negedge clk_i);
        apply_row('0);
        check_en = 1'b0;

        waited = 0;
        while ((pass_cnt + fail_cnt < rows.size()) && (waited < DONE_WAIT)) begin
            @(posedge clk_i);
            waited++;
        end
        if (pass_cnt + fail_cnt < rows.size()) begin
            $display("Checker reported only %0d of %0d rows in time",
                     pass_cnt + fail_cnt, rows.size());
            $display("test failed");
        end else begin
            $display("Rows passed: %0d, rows failed: %0d", pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
fetch_pkg.sv
branch_predictor.sv
fetch_stage.sv
instr_store.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build the fetch front end testbench with Verilator and run it.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_fetch -o tb_fetch \
    && ./obj_dir/tb_fetch | awk '{ print } /^test passed$/ { ok = 1 } END { exit !ok }' \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }
